// File: hw/cache_cfg_pkg.sv
package cache_cfg_pkg;

	// --------------------------------------------------
	// address geometry
	// --------------------------------------------------

	// core addresses count words, not bytes
	localparam int BW_WORD_ADDR = 16;

	localparam int BW_BLOCK = 2;                              // word offset inside a block
	localparam int WORDS_PER_BLOCK = 1 << BW_BLOCK;           // 4 words per block

	// tag is everything above the word offset
	localparam int BW_TAG = BW_WORD_ADDR - BW_BLOCK;

	// --------------------------------------------------
	// data path
	// --------------------------------------------------

	localparam int BW_DATA = 32;                              // core and buffer word width

endpackage

// File: hw/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

	// controller FSM, one core request in flight at a time
	typedef enum logic [2:0] {
		IDLE,           // waiting for core_req_i with enable high
		LOOKUP,         // tag compare, hit access issued to data memory
		HIT_DONE,       // read data valid, done to core
		WB_REQ,         // writeback command to buffer
		WB_WORD,        // streaming dirty victim words out
		FILL_REQ,       // fill command to buffer
		FILL_WORD,      // streaming new block words in
		FILL_DONE       // finish original access, update tag
	} cache_state_e;

	// apb word offsets of the perf unit
	typedef enum logic [3:0] {
		REG_HIT   = 4'h0,   // hit counter, read only
		REG_MISS  = 4'h4,   // miss counter, read only
		REG_WB    = 4'h8,   // writeback counter, read only
		REG_CLEAR = 4'hC    // any write clears all counters
	} perf_reg_e;

endpackage

// File: hw/tag_memory_fa.sv
`timescale 1ns/1ps

module tag_memory_fa import cache_cfg_pkg::*; #(
	parameter int CACHE_BLOCK_CAPACITY = 8
) (
	input  logic                                    clock_i,
	input  logic                                    rst_i,
	input  logic                                    wren_i,   // write tag_i into entry add_i
	input  logic [BW_TAG-1:0]                       tag_i,    // lookup key, also write data
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] add_i,    // entry to write or read back
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] add_o,    // entry holding tag_i
	output logic [BW_TAG-1:0]                       tag_o,    // tag stored at add_i
	output logic                                    hit_o
);

	localparam int BW_IDX = $clog2(CACHE_BLOCK_CAPACITY);

	logic [BW_TAG-1:0]               tags_q [CACHE_BLOCK_CAPACITY];
	logic [CACHE_BLOCK_CAPACITY-1:0] valid_q;
	logic [CACHE_BLOCK_CAPACITY-1:0] match;

	// --------------------------------------------------
	// storage
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			valid_q <= '0;                // cache starts empty
		end else if (wren_i) begin
			valid_q[add_i] <= 1'b1;       // entries are never invalidated
		end
	end

	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			tags_q[add_i] <= tag_i;
		end
	end

	// --------------------------------------------------
	// parallel compare and encode
	// --------------------------------------------------
	always_comb begin
		add_o = '0;
		for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
			match[i] = valid_q[i] && (tags_q[i] == tag_i);
			if (match[i]) begin
				add_o = BW_IDX'(i);       // at most one match, see below
			end
		end
	end

	assign hit_o = |match;
	assign tag_o = tags_q[add_i];         // victim tag for writeback address

	// the controller only writes a tag after a miss on it, so entries stay unique
	a_unique_match : assert property (@(posedge clock_i) disable iff (rst_i)
		$onehot0(match));

endmodule

// File: hw/cache_data_mem.sv
`timescale 1ns/1ps

module cache_data_mem import cache_cfg_pkg::*; #(
	parameter int CACHE_BLOCK_CAPACITY = 8
) (
	input  logic                                             clock_i,
	input  logic                                             wren_i,
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)+BW_BLOCK-1:0] add_i,   // [block|word]
	input  logic [BW_DATA-1:0]                               data_i,
	output logic [BW_DATA-1:0]                               data_o   // one cycle after add_i
);

	localparam int DEPTH = CACHE_BLOCK_CAPACITY * WORDS_PER_BLOCK;

	logic [BW_DATA-1:0] mem_q [DEPTH];

	// single port, read returns old contents on a write cycle
	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			mem_q[add_i] <= data_i;
		end
		data_o <= mem_q[add_i];            // registered read
	end

endmodule

// File: hw/cache_controller.sv
`timescale 1ns/1ps

module cache_controller import cache_cfg_pkg::*, cache_ctrl_pkg::*; #(
	parameter int CACHE_BLOCK_CAPACITY = 8
) (
	input  logic                                             clock_i,
	input  logic                                             rst_i,
	input  logic                                             enable_i,
	// core side
	input  logic                                             core_req_i,
	input  logic                                             core_rw_i,     // 1 = write
	input  logic [BW_TAG-1:0]                                core_tag_i,
	input  logic [BW_BLOCK-1:0]                              core_word_i,
	input  logic [BW_DATA-1:0]                               core_data_i,
	output logic                                             core_done_o,
	output logic                                             core_hit_o,
	output logic [BW_DATA-1:0]                               core_data_o,
	// tag memory
	input  logic                                             cam_hit_i,
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0]          cam_addr_i,    // index of matching tag
	input  logic [BW_TAG-1:0]                                cam_tag_i,     // tag at cam_addr_o
	output logic                                             cam_wren_o,
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0]          cam_addr_o,
	// data memory
	input  logic [BW_DATA-1:0]                               cache_mem_data_i,
	output logic [$clog2(CACHE_BLOCK_CAPACITY)+BW_BLOCK-1:0] cache_mem_add_o,
	output logic                                             cache_mem_rw_o,
	output logic [BW_DATA-1:0]                               cache_mem_data_o,
	// buffer side
	input  logic                                             mem_ready_i,
	input  logic                                             mem_ready_read_i,
	input  logic                                             mem_ready_write_i,
	input  logic [BW_DATA-1:0]                               buffer_data_i,
	output logic                                             mem_req_o,
	output logic                                             mem_req_block_o,
	output logic                                             mem_rw_o,      // 1 = writeback
	output logic [BW_WORD_ADDR-1:0]                          mem_addr_o,
	output logic [BW_DATA-1:0]                               buffer_data_o,
	output logic                                             read_o,
	output logic                                             write_o,
	// perf flags, one cycle each
	output logic                                             flag_hit_o,
	output logic                                             flag_miss_o,
	output logic                                             flag_writeback_o
);

	localparam int BW_IDX = $clog2(CACHE_BLOCK_CAPACITY);

	cache_state_e                    state_q, state_d;
	logic [BW_IDX-1:0]               victim_q;          // round-robin replacement pointer
	logic [CACHE_BLOCK_CAPACITY-1:0] dirty_q;
	logic [BW_BLOCK-1:0]             cnt_q, cnt_nxt;    // word counter for wb and fill
	logic [BW_DATA-1:0]              fill_word_q;       // requested word caught during fill
	logic                            last_word;

	assign cnt_nxt   = cnt_q + 1'b1;
	assign last_word = &cnt_q;

	// --------------------------------------------------
	// next state
	// --------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:      if (enable_i && core_req_i) state_d = LOOKUP;
			LOOKUP: begin
				if (cam_hit_i) state_d = HIT_DONE;
				else if (dirty_q[victim_q]) state_d = WB_REQ;     // dirty implies valid
				else state_d = FILL_REQ;
			end
			HIT_DONE:  state_d = IDLE;
			WB_REQ:    if (mem_ready_i) state_d = WB_WORD;
			WB_WORD:   if (write_o && last_word) state_d = FILL_REQ;
			FILL_REQ:  if (mem_ready_i) state_d = FILL_WORD;
			FILL_WORD: if (read_o && last_word) state_d = FILL_DONE;
			FILL_DONE: state_d = IDLE;
			default:   state_d = IDLE;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			state_q  <= IDLE;
			victim_q <= '0;
			dirty_q  <= '0;
			cnt_q    <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == LOOKUP && cam_hit_i && core_rw_i) begin
				dirty_q[cam_addr_i] <= 1'b1;                        // write hit
			end
			if (state_q == FILL_DONE) begin
				dirty_q[victim_q] <= core_rw_i;                     // new block, dirty only on write miss
				victim_q <= victim_q + 1'b1;                        // wraps, capacity is a power of two
			end
			if (write_o || read_o) cnt_q <= cnt_nxt;                // wraps back to 0 after 4 words
		end
	end

	always_ff @(posedge clock_i) begin
		if (read_o && cnt_q == core_word_i) fill_word_q <= buffer_data_i;
	end

	// --------------------------------------------------
	// data memory port
	// --------------------------------------------------
	always_comb begin
		cache_mem_add_o  = {victim_q, cnt_q};      // wb_req prefetches word 0 here
		cache_mem_rw_o   = 1'b0;
		cache_mem_data_o = core_data_i;
		case (state_q)
			LOOKUP: begin
				cache_mem_add_o = {cam_addr_i, core_word_i};
				cache_mem_rw_o  = cam_hit_i && core_rw_i;
			end
			WB_WORD:   if (write_o) cache_mem_add_o = {victim_q, cnt_nxt};   // next word ready in time
			FILL_WORD: begin
				cache_mem_rw_o   = read_o;
				cache_mem_data_o = buffer_data_i;
			end
			FILL_DONE: begin
				cache_mem_add_o = {victim_q, core_word_i};
				cache_mem_rw_o  = core_rw_i;        // write miss lands on the fresh block
			end
			default: ;
		endcase
	end

	// --------------------------------------------------
	// outputs
	// --------------------------------------------------
	assign core_done_o = (state_q == HIT_DONE) || (state_q == FILL_DONE);
	assign core_hit_o  = (state_q == HIT_DONE);
	assign core_data_o = (state_q == FILL_DONE) ? fill_word_q : cache_mem_data_i;

	assign cam_wren_o = (state_q == FILL_DONE);
	assign cam_addr_o = victim_q;                 // also selects the writeback tag

	assign mem_req_o       = (state_q == WB_REQ) || (state_q == FILL_REQ);
	assign mem_req_block_o = mem_req_o;           // always whole blocks
	assign mem_rw_o        = (state_q == WB_REQ);
	assign mem_addr_o      = {(state_q == WB_REQ) ? cam_tag_i : core_tag_i, {BW_BLOCK{1'b0}}};
	assign buffer_data_o   = cache_mem_data_i;
	assign write_o         = (state_q == WB_WORD) && mem_ready_write_i;
	assign read_o          = (state_q == FILL_WORD) && mem_ready_read_i;

	assign flag_hit_o       = (state_q == LOOKUP) && cam_hit_i;
	assign flag_miss_o      = (state_q == LOOKUP) && !cam_hit_i;
	assign flag_writeback_o = (state_q == WB_REQ) && mem_ready_i;

	a_req_stable : assert property (@(posedge clock_i) disable iff (rst_i)
		mem_req_o && !mem_ready_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_rw_o));

	a_done_pulse : assert property (@(posedge clock_i) disable iff (rst_i)
		core_done_o |=> !core_done_o);

endmodule

// File: hw/cache_perf_apb.sv
`timescale 1ns/1ps

module cache_perf_apb import cache_cfg_pkg::*, cache_ctrl_pkg::*; (
	input  logic                         clock_i,
	input  logic                         rst_i,
	input  logic                         hit_i,
	input  logic                         miss_i,
	input  logic                         writeback_i,
	// apb slave
	input  logic                         psel_i,
	input  logic                         penable_i,
	input  logic                         pwrite_i,
	input  logic [$bits(perf_reg_e)-1:0] paddr_i,
	input  logic [BW_DATA-1:0]           pwdata_i,
	output logic [BW_DATA-1:0]           prdata_o,
	output logic                         pready_o,
	output logic                         pslverr_o
);

	logic [BW_DATA-1:0] cnt_q [3];        // 0 hit, 1 miss, 2 writeback
	logic [2:0]         evt;
	logic               access, clear, reg_err;

	assign evt    = {writeback_i, miss_i, hit_i};
	assign access = psel_i && penable_i;
	// a write of any value to REG_CLEAR empties all counters
	assign clear  = access && pwrite_i && (paddr_i == REG_CLEAR);

	// --------------------------------------------------
	// saturating counters
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		for (int i = 0; i < 3; i++) begin
			if (rst_i || clear) cnt_q[i] <= '0;
			else if (evt[i] && cnt_q[i] != '1) cnt_q[i] <= cnt_q[i] + 1'b1;
		end
	end

	// --------------------------------------------------
	// read decode without wait states
	// --------------------------------------------------
	always_comb begin
		prdata_o = '0;
		reg_err  = 1'b0;
		case (paddr_i)
			REG_HIT:   begin prdata_o = cnt_q[0]; reg_err = pwrite_i; end
			REG_MISS:  begin prdata_o = cnt_q[1]; reg_err = pwrite_i; end
			REG_WB:    begin prdata_o = cnt_q[2]; reg_err = pwrite_i; end
			REG_CLEAR: prdata_o = '0;            // write only in effect
			default:   reg_err = 1'b1;           // unmapped offset
		endcase
	end

	assign pready_o  = access;
	assign pslverr_o = access && reg_err;

	a_apb_setup : assert property (@(posedge clock_i) disable iff (rst_i)
		$rose(penable_i) |-> psel_i && $past(psel_i));

endmodule

// File: hw/cache_fa_top.sv
`timescale 1ns/1ps

module cache_fa_top import cache_cfg_pkg::*, cache_ctrl_pkg::*; #(
	parameter int CACHE_BLOCK_CAPACITY = 8
) (
	input  logic                         clock_i,
	input  logic                         rst_i,
	input  logic                         en_i,
	// core
	input  logic                         core_req_i,
	input  logic                         core_rw_i,
	input  logic [BW_WORD_ADDR-1:0]      core_add_i,
	input  logic [BW_DATA-1:0]           core_data_i,
	output logic                         core_done_o,
	output logic                         core_hit_o,
	output logic [BW_DATA-1:0]           core_data_o,
	// buffer
	input  logic                         mem_ready_i,
	input  logic                         mem_ready_read_i,
	input  logic                         mem_ready_write_i,
	input  logic [BW_DATA-1:0]           data_i,
	output logic                         mem_req_o,
	output logic                         mem_req_block_o,
	output logic                         mem_rw_o,
	output logic [BW_WORD_ADDR-1:0]      mem_add_o,
	output logic [BW_DATA-1:0]           data_o,
	output logic                         read_o,
	output logic                         write_o,
	// apb
	input  logic                         psel_i,
	input  logic                         penable_i,
	input  logic                         pwrite_i,
	input  logic [$bits(perf_reg_e)-1:0] paddr_i,
	input  logic [BW_DATA-1:0]           pwdata_i,
	output logic [BW_DATA-1:0]           prdata_o,
	output logic                         pready_o,
	output logic                         pslverr_o
);

	localparam int BW_IDX = $clog2(CACHE_BLOCK_CAPACITY);

	// --------------------------------------------------
	// address split and internal nets
	// --------------------------------------------------
	logic [BW_TAG-1:0]          req_tag;
	logic [BW_BLOCK-1:0]        req_word;
	logic                       cam_wren, cam_hit;
	logic [BW_IDX-1:0]          cam_index, cam_index_hit;
	logic [BW_TAG-1:0]          cam_tag_at_index;
	logic                       dmem_wren;
	logic [BW_IDX+BW_BLOCK-1:0] dmem_add;       // [block|word]
	logic [BW_DATA-1:0]         dmem_wdata, dmem_rdata;
	logic                       flag_hit, flag_miss, flag_wb;

	assign req_tag  = core_add_i[BW_WORD_ADDR-1:BW_BLOCK];
	assign req_word = core_add_i[BW_BLOCK-1:0];

	tag_memory_fa #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) i_tag_mem (
		.clock_i (clock_i), .rst_i (rst_i), .wren_i (cam_wren), .tag_i (req_tag),
		.add_i (cam_index), .add_o (cam_index_hit), .tag_o (cam_tag_at_index), .hit_o (cam_hit)
	);

	cache_data_mem #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) i_data_mem (
		.clock_i (clock_i), .wren_i (dmem_wren), .add_i (dmem_add),
		.data_i (dmem_wdata), .data_o (dmem_rdata)
	);

	cache_controller #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) i_ctrl (
		.clock_i (clock_i), .rst_i (rst_i), .enable_i (en_i),
		.core_req_i (core_req_i), .core_rw_i (core_rw_i), .core_tag_i (req_tag),
		.core_word_i (req_word), .core_data_i (core_data_i), .core_done_o (core_done_o),
		.core_hit_o (core_hit_o), .core_data_o (core_data_o),
		.cam_hit_i (cam_hit), .cam_addr_i (cam_index_hit), .cam_tag_i (cam_tag_at_index),
		.cam_wren_o (cam_wren), .cam_addr_o (cam_index),
		.cache_mem_data_i (dmem_rdata), .cache_mem_add_o (dmem_add),
		.cache_mem_rw_o (dmem_wren), .cache_mem_data_o (dmem_wdata),
		.mem_ready_i (mem_ready_i), .mem_ready_read_i (mem_ready_read_i),
		.mem_ready_write_i (mem_ready_write_i), .buffer_data_i (data_i),
		.mem_req_o (mem_req_o), .mem_req_block_o (mem_req_block_o), .mem_rw_o (mem_rw_o),
		.mem_addr_o (mem_add_o), .buffer_data_o (data_o), .read_o (read_o), .write_o (write_o),
		.flag_hit_o (flag_hit), .flag_miss_o (flag_miss), .flag_writeback_o (flag_wb)
	);

	cache_perf_apb i_perf (
		.clock_i (clock_i), .rst_i (rst_i), .hit_i (flag_hit), .miss_i (flag_miss),
		.writeback_i (flag_wb), .psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
		.paddr_i (paddr_i), .pwdata_i (pwdata_i), .prdata_o (prdata_o), .pready_o (pready_o),
		.pslverr_o (pslverr_o)
	);

endmodule

// File: bench/ext_mem_model.sv
`timescale 1ns/1ps

module ext_mem_model import cache_cfg_pkg::*; (
	input  logic                    clock_i,
	input  logic                    rst_i,
	input  logic [1:0]              delay_i,      // wait cycles after each transfer
	input  logic                    mem_req_i,
	input  logic                    mem_rw_i,     // 1 = writeback
	input  logic [BW_WORD_ADDR-1:0] mem_add_i,
	input  logic [BW_DATA-1:0]      data_i,
	input  logic                    read_i,
	input  logic                    write_i,
	output logic                    mem_ready_o,
	output logic                    mem_ready_read_o,
	output logic                    mem_ready_write_o,
	output logic [BW_DATA-1:0]      data_o,
	output logic                    wb_o,         // one written word seen last edge
	output logic [BW_WORD_ADDR-1:0] wb_addr_o,
	output logic [BW_DATA-1:0]      wb_data_o
);

	logic [BW_DATA-1:0]      store [1 << BW_WORD_ADDR];
	logic                    active_q, rw_q, xfer_q;
	logic [BW_WORD_ADDR-1:0] base_q;
	logic [BW_BLOCK-1:0]     cnt_q;               // word in the current block
	logic [1:0]              wait_q;

	initial begin
		for (int a = 0; a < (1 << BW_WORD_ADDR); a++) begin
			store[a] = {16'(a) ^ 16'hC3A5, 16'(a)};   // every word tells its own address
		end
		{active_q, rw_q, xfer_q, wb_o} = '0;
		{mem_ready_o, mem_ready_read_o, mem_ready_write_o} = '0;
		base_q    = '0;
		cnt_q     = '0;
		wait_q    = '0;
		data_o    = '0;
		wb_addr_o = '0;
		wb_data_o = '0;
	end

	// --------------------------------------------------
	// command and word transfers, on the dut edge
	// --------------------------------------------------
	always @(posedge clock_i) begin
		xfer_q <= 1'b0;
		wb_o   <= 1'b0;
		if (rst_i) begin
			active_q <= 1'b0;
		end else if (mem_req_i && mem_ready_o && !active_q) begin
			active_q <= 1'b1;                    // block command accepted
			rw_q     <= mem_rw_i;
			base_q   <= mem_add_i;
			cnt_q    <= '0;
			xfer_q   <= 1'b1;
		end else if (read_i || write_i) begin
			if (write_i) begin
				store[base_q + cnt_q] <= data_i;
				wb_o      <= 1'b1;
				wb_addr_o <= base_q + cnt_q;
				wb_data_o <= data_i;
			end
			cnt_q    <= cnt_q + 1'b1;
			active_q <= (cnt_q != '1);          // last word ends the burst
			xfer_q   <= 1'b1;
		end
	end

	// ready lines change on the falling edge only
	always @(negedge clock_i) begin
		if (rst_i) begin
			wait_q = '0;
			mem_ready_o       <= 1'b0;
			mem_ready_read_o  <= 1'b0;
			mem_ready_write_o <= 1'b0;
		end else begin
			if (xfer_q) wait_q = delay_i;        // fresh random gap after every step
			else if (wait_q != '0) wait_q = wait_q - 1'b1;
			mem_ready_o       <= (wait_q == '0) && mem_req_i && !active_q;
			mem_ready_read_o  <= (wait_q == '0) && active_q && !rw_q;
			mem_ready_write_o <= (wait_q == '0) && active_q && rw_q;
		end
		data_o <= store[base_q + cnt_q];         // next fill word
	end

endmodule

// File: bench/cache_fa_tb.sv
`timescale 1ns/1ps

module cache_fa_tb import cache_cfg_pkg::*, cache_ctrl_pkg::*; ();

	localparam int CAPACITY   = 8;
	localparam int N_REQ      = 400;
	localparam int WORST_MISS = 40;                          // dirty miss with slow buffer
	localparam int EN_LOW_REQ = 200;                         // this request waits with en_i low
	localparam int TIMEOUT    = N_REQ * WORST_MISS + 300;    // plus en low gap and apb

	logic                    clock, rst, en;
	logic                    core_req, core_rw, core_done, core_hit;
	logic [BW_WORD_ADDR-1:0] core_add;
	logic [BW_DATA-1:0]      core_wdata, core_rdata;
	logic                    mem_ready, mem_ready_read, mem_ready_write;
	logic                    mem_req, mem_req_block, mem_rw, rd_ack, wr_ack;
	logic [BW_WORD_ADDR-1:0] mem_add, wb_addr;
	logic [BW_DATA-1:0]      buf_rdata, buf_wdata, wb_data;
	logic                    psel, penable, pwrite, pready, pslverr, wb_seen;
	logic [3:0]              paddr;
	logic [BW_DATA-1:0]      pwdata, prdata;
	logic [1:0]              mem_delay;
	logic [15:0]             lfsr_stim, lfsr_mem;

	// reference model state
	logic [BW_DATA-1:0] golden [128];                        // 32 blocks of 4 words
	int                 tag_m [CAPACITY];                    // -1 marks an empty entry
	logic               dirty_m [CAPACITY];
	int                 vic_m, n_hit, n_miss, n_wb, wb_words, cycle_cnt;
	logic [4:0]         exp_wb_blk;

	cache_fa_top #(.CACHE_BLOCK_CAPACITY(CAPACITY)) i_cache_fa_top (
		.clock_i (clock), .rst_i (rst), .en_i (en),
		.core_req_i (core_req), .core_rw_i (core_rw), .core_add_i (core_add),
		.core_data_i (core_wdata), .core_done_o (core_done), .core_hit_o (core_hit),
		.core_data_o (core_rdata),
		.mem_ready_i (mem_ready), .mem_ready_read_i (mem_ready_read),
		.mem_ready_write_i (mem_ready_write), .data_i (buf_rdata), .mem_req_o (mem_req),
		.mem_req_block_o (mem_req_block), .mem_rw_o (mem_rw), .mem_add_o (mem_add),
		.data_o (buf_wdata), .read_o (rd_ack), .write_o (wr_ack),
		.psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
		.pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr)
	);

	ext_mem_model i_mem (
		.clock_i (clock), .rst_i (rst), .delay_i (mem_delay), .mem_req_i (mem_req),
		.mem_rw_i (mem_rw), .mem_add_i (mem_add), .data_i (buf_wdata), .read_i (rd_ack),
		.write_i (wr_ack), .mem_ready_o (mem_ready), .mem_ready_read_o (mem_ready_read),
		.mem_ready_write_o (mem_ready_write), .data_o (buf_rdata), .wb_o (wb_seen),
		.wb_addr_o (wb_addr), .wb_data_o (wb_data)
	);

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};    // x^16+x^14+x^13+x^11+1
	endfunction

	task automatic draw_bits(input int n, inout logic [15:0] s, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			s = lfsr_next(s);                                // one step per bit
			v = {v[30:0], s[0]};
		end
	endtask

	function automatic logic [15:0] word_addr(input logic [4:0] blk, input logic [1:0] word);
		return {blk, 9'd0, word};                            // block number in the top tag bits
	endfunction

	function automatic logic [31:0] fill_pattern(input logic [15:0] a);
		return {a ^ 16'hC3A5, a};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			$display("Done: errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rd, output logic err);
		@(negedge clock);
		psel    = 1'b1;                                      // setup phase
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clock);
		penable = 1'b1;                                      // access phase
		#1;
		check_value("pready_o", pready, 1'b1);
		rd  = prdata;
		err = pslverr;
		@(negedge clock);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_counters(input int h, input int m, input int w);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b0, REG_HIT, '0, rd, err);
		check_value("prdata_o REG_HIT", rd, h);
		check_value("pslverr_o", err, 1'b0);
		apb_access(1'b0, REG_MISS, '0, rd, err);
		check_value("prdata_o REG_MISS", rd, m);
		check_value("pslverr_o", err, 1'b0);
		apb_access(1'b0, REG_WB, '0, rd, err);
		check_value("prdata_o REG_WB", rd, w);
		check_value("pslverr_o", err, 1'b0);
	endtask

	// predict with the model, run one core access, compare
	task automatic run_request(input logic rw, input logic [4:0] blk, input logic [1:0] word,
		input logic [31:0] wdata, input int en_low);
		int          cycles;
		int          slot;
		logic [31:0] exp_rd;
		exp_rd = golden[{blk, word}];
		slot   = -1;
		for (int i = 0; i < CAPACITY; i++) begin
			if (tag_m[i] == blk) slot = i;
		end
		if (slot >= 0) begin
			n_hit++;
			if (rw) dirty_m[slot] = 1'b1;
		end else begin
			n_miss++;
			if (dirty_m[vic_m]) begin                        // dirty victim goes out first
				n_wb++;
				exp_wb_blk = 5'(tag_m[vic_m]);
			end
			tag_m[vic_m]   = blk;
			dirty_m[vic_m] = rw;
			vic_m          = (vic_m + 1) % CAPACITY;         // round robin
		end
		if (rw) golden[{blk, word}] = wdata;
		@(negedge clock);
		en         = (en_low == 0);
		core_req   = 1'b1;
		core_rw    = rw;
		core_add   = word_addr(blk, word);
		core_wdata = wdata;
		cycles     = 0;
		do begin
			@(negedge clock);
			cycles++;
			if (cycles <= en_low) check_value("core_done_o", core_done, 1'b0);
			if (cycles == en_low) en = 1'b1;
		end while (!core_done);
		check_value("core_hit_o", core_hit, slot >= 0);
		if (slot >= 0) check_value("core_done_o latency", cycles, en_low + 2);
		if (!rw) check_value("core_data_o", core_rdata, exp_rd);
		check_value("write_o word count", wb_words, 4 * n_wb);   // clean victims stay quiet
		core_req = 1'b0;
	endtask

	// --------------------------------------------------
	// clock, timeout, buffer delays, buffer checks
	// --------------------------------------------------
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT) begin
			$display("Done: errors found");
			$fatal(1, "timeout, the run did not finish within %0d cycles", TIMEOUT);
		end
	end

	always @(negedge clock) begin : delay_gen
		logic [31:0] dv;
		draw_bits(2, lfsr_mem, dv);
		mem_delay <= dv[1:0];                                // 0 to 3 wait cycles
	end

	always @(negedge clock) begin
		if (mem_req) check_value("mem_req_block_o", mem_req_block, 1'b1);   // whole blocks only
		if (wb_seen) begin
			check_value("mem_add_o", wb_addr & 16'hFFFC, word_addr(exp_wb_blk, 2'd0));
			check_value("data_o", wb_data, golden[{wb_addr[15:11], wb_addr[1:0]}]);
			wb_words++;
		end
	end

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		logic [31:0] v;
		logic [31:0] rd;
		logic        err;
		logic        rw;
		logic [4:0]  blk;
		logic [1:0]  word;
		{rst, en, core_req, core_rw, psel, penable, pwrite} = 7'b1000000;
		core_add   = '0;
		core_wdata = '0;
		paddr      = '0;
		pwdata     = '0;
		mem_delay  = '0;
		lfsr_stim  = 16'd17498;
		lfsr_mem   = 16'd17498;
		{vic_m, n_hit, n_miss, n_wb, wb_words, cycle_cnt} = '0;
		exp_wb_blk = '0;
		for (int i = 0; i < 128; i++) golden[i] = fill_pattern(word_addr(i[6:2], i[1:0]));
		for (int i = 0; i < CAPACITY; i++) begin
			tag_m[i]   = -1;
			dirty_m[i] = 1'b0;
		end
		repeat (10) @(negedge clock);
		rst = 1'b0;
		@(negedge clock);
		check_value("core_done_o", core_done, 1'b0);         // quiet after reset
		check_value("mem_req_o", mem_req, 1'b0);
		check_value("read_o", rd_ack, 1'b0);
		check_value("write_o", wr_ack, 1'b0);
		check_value("pslverr_o", pslverr, 1'b0);
		check_counters(0, 0, 0);
		en = 1'b1;
		for (int n = 0; n < N_REQ; n++) begin
			draw_bits(1, lfsr_stim, v);
			rw = v[0];
			draw_bits(5, lfsr_stim, v);
			blk = v[4:0];                                    // 32 blocks over 8 entries
			draw_bits(2, lfsr_stim, v);
			word = v[1:0];
			draw_bits(32, lfsr_stim, v);
			run_request(rw, blk, word, v, (n == EN_LOW_REQ) ? 20 : 0);
		end
		check_counters(n_hit, n_miss, n_wb);
		apb_access(1'b1, REG_CLEAR, 32'h1234_5678, rd, err);
		check_value("pslverr_o", err, 1'b0);
		check_counters(0, 0, 0);
		apb_access(1'b1, REG_HIT, 32'h1, rd, err);          // counters are read only
		check_value("pslverr_o", err, 1'b1);
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: cache_fa_top.f
hw/cache_cfg_pkg.sv
hw/cache_ctrl_pkg.sv
hw/tag_memory_fa.sv
hw/cache_data_mem.sv
hw/cache_controller.sv
hw/cache_perf_apb.sv
hw/cache_fa_top.sv
bench/ext_mem_model.sv
bench/cache_fa_tb.sv

// File: Bender.yml
package:
  name: cache_fa

sources:
  - hw/cache_cfg_pkg.sv
  - hw/cache_ctrl_pkg.sv
  - hw/tag_memory_fa.sv
  - hw/cache_data_mem.sv
  - hw/cache_controller.sv
  - hw/cache_perf_apb.sv
  - hw/cache_fa_top.sv
  - target: test
    files:
      - bench/ext_mem_model.sv
      - bench/cache_fa_tb.sv
